/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert -j 0
TOP         = tb_cpu_bus_subsys
FILELIST    = tb.f
OBJ_DIR     = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* source/ahb_dual_sram.sv */
// Dual-ported AHB-Lite SRAM slave
// Fetch port has no wait states, data port one wait state and byte-lane writes
// Accesses past the end of memory get the two-cycle error response

`default_nettype none

module ahb_dual_sram (
	input  wire                           clk,
	input  wire                           rst_n,
	// Fetch slave port
	input  wire  [ahb_pkg::W_ADDR-1:0]    i_haddr_i,
	input  wire  [ahb_pkg::W_HTRANS-1:0]  i_htrans_i,
	input  wire  [ahb_pkg::W_HSIZE-1:0]   i_hsize_i,
	output logic                          i_hready_o,
	output logic                          i_hresp_o,
	output logic [ahb_pkg::W_DATA-1:0]    i_hrdata_o,
	// Data slave port
	input  wire  [ahb_pkg::W_ADDR-1:0]    d_haddr_i,
	input  wire  [ahb_pkg::W_HTRANS-1:0]  d_htrans_i,
	input  wire  [ahb_pkg::W_HSIZE-1:0]   d_hsize_i,
	input  wire                           d_hwrite_i,
	input  wire  [ahb_pkg::W_DATA-1:0]    d_hwdata_i,
	output logic                          d_hready_o,
	output logic                          d_hresp_o,
	output logic [ahb_pkg::W_DATA-1:0]    d_hrdata_o
);

sram_pkg::mem_word_u mem [sram_pkg::MEM_WORDS];

logic [sram_pkg::W_PH-1:0]    i_ph;
logic [sram_pkg::W_PH-1:0]    d_ph;
logic [sram_pkg::W_INDEX-1:0] i_idx;
logic [sram_pkg::W_INDEX-1:0] d_idx;
logic [sram_pkg::N_LANES-1:0] d_mask;
logic                         d_write;
logic                         i_accept;
logic                         d_accept;
sram_pkg::mem_word_u          wdata;

// Out of range, or wider than the bus
function automatic logic bad_xfer(input logic [ahb_pkg::W_ADDR-1:0] addr,
		input logic [ahb_pkg::W_HSIZE-1:0] size);
	bad_xfer = (addr >= sram_pkg::MEM_BYTES) || (size > ahb_pkg::HSIZE_WORD);
endfunction

// Data phase sequence, slow adds the wait state
function automatic logic [sram_pkg::W_PH-1:0] next_ph(input logic [sram_pkg::W_PH-1:0] cur,
		input logic accept, input logic bad, input logic slow);
	if (cur == sram_pkg::PH_WAIT)
		next_ph = sram_pkg::PH_OKAY;
	else if (cur == sram_pkg::PH_ERR1)
		next_ph = sram_pkg::PH_ERR2;
	else if (!accept)
		next_ph = sram_pkg::PH_IDLE;
	else if (bad)
		next_ph = sram_pkg::PH_ERR1;
	else
		next_ph = slow ? sram_pkg::PH_WAIT : sram_pkg::PH_OKAY;
endfunction

function automatic logic [sram_pkg::N_LANES-1:0] lane_mask(input logic [ahb_pkg::W_HSIZE-1:0] size,
		input logic [1:0] lsb);
	case (size)
		ahb_pkg::HSIZE_BYTE: lane_mask = 4'b0001 << lsb;
		ahb_pkg::HSIZE_HALF: lane_mask = 4'b0011 << {lsb[1], 1'b0};
		default:             lane_mask = 4'b1111;
	endcase
endfunction

assign i_accept = (i_htrans_i == ahb_pkg::HTRANS_NSEQ) && i_hready_o;
assign d_accept = (d_htrans_i == ahb_pkg::HTRANS_NSEQ) && d_hready_o;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		i_ph    <= sram_pkg::PH_IDLE;
		d_ph    <= sram_pkg::PH_IDLE;
		d_write <= 1'b0;
	end else begin
		i_ph <= next_ph(i_ph, i_accept, bad_xfer(i_haddr_i, i_hsize_i), 1'b0);
		d_ph <= next_ph(d_ph, d_accept, bad_xfer(d_haddr_i, d_hsize_i), 1'b1);
		if (d_hready_o)
			d_write <= d_accept && d_hwrite_i;
	end
end

// Address phase capture
always_ff @(posedge clk) begin
	if (i_accept)
		i_idx <= i_haddr_i[sram_pkg::W_INDEX+1:2];
	if (d_accept) begin
		d_idx  <= d_haddr_i[sram_pkg::W_INDEX+1:2];
		d_mask <= lane_mask(d_hsize_i, d_haddr_i[1:0]);
	end
end

assign i_hready_o = (i_ph != sram_pkg::PH_WAIT) && (i_ph != sram_pkg::PH_ERR1);
assign i_hresp_o  = (i_ph == sram_pkg::PH_ERR1) || (i_ph == sram_pkg::PH_ERR2);
assign d_hready_o = (d_ph != sram_pkg::PH_WAIT) && (d_ph != sram_pkg::PH_ERR1);
assign d_hresp_o  = (d_ph == sram_pkg::PH_ERR1) || (d_ph == sram_pkg::PH_ERR2);

// --------------------------------------------------------------------------
// Storage

// Write lands at the end of the data phase, so a fetch of the same
// word in that cycle still reads the old contents
assign wdata = sram_pkg::mem_word_u'(d_hwdata_i);

always_ff @(posedge clk) begin
	if ((d_ph == sram_pkg::PH_OKAY) && d_write) begin
		for (int k = 0; k < sram_pkg::N_LANES; k++) begin
			if (d_mask[k])
				mem[d_idx].lanes[k] <= wdata.lanes[k];
		end
	end
end

assign i_hrdata_o = mem[i_idx].word;
assign d_hrdata_o = mem[d_idx].word;

a_d_aligned: assert property (@(posedge clk) disable iff (!rst_n)
	d_accept |-> ((d_hsize_i != ahb_pkg::HSIZE_HALF) || !d_haddr_i[0])
		&& ((d_hsize_i != ahb_pkg::HSIZE_WORD) || (d_haddr_i[1:0] == 2'b00)))
	else $error("data port transfer misaligned for its size");

a_d_waddr_known: assert property (@(posedge clk) disable iff (!rst_n)
	d_accept && d_hwrite_i |-> !$isunknown(d_haddr_i))
	else $error("data port write with unknown address");

endmodule

`default_nettype wire

/* source/ahb_pkg.sv */
// AHB-Lite encodings shared by the bus masters and the SRAM slave
// Transfer types, transfer sizes, protection bit positions and bus widths

`default_nettype none

package ahb_pkg;

	// ------------------------------------------------------------------------
	// Bus widths
	localparam int W_ADDR   = 32;
	localparam int W_DATA   = 32;
	localparam int W_HTRANS = 2;
	localparam int W_HSIZE  = 3;
	localparam int W_HPROT  = 4;

	// ------------------------------------------------------------------------
	// HTRANS codes, only single transfers are issued
	localparam logic [W_HTRANS-1:0] HTRANS_IDLE = 2'b00;
	localparam logic [W_HTRANS-1:0] HTRANS_NSEQ = 2'b10;

	// HSIZE codes up to one full word
	localparam logic [W_HSIZE-1:0] HSIZE_BYTE = 3'b000;
	localparam logic [W_HSIZE-1:0] HSIZE_HALF = 3'b001;
	localparam logic [W_HSIZE-1:0] HSIZE_WORD = 3'b010;

	// HPROT bit positions
	// Bit 0 set means data access, clear means opcode fetch
	localparam int HPROT_DATA_BIT = 0;
	// Bit 1 set means privileged access
	localparam int HPROT_PRIV_BIT = 1;

endpackage

`default_nettype wire

/* source/cpu_bus_subsys.sv */
// Bus subsystem top level
// Fetch port and shared load/store port, both ending in a dual-ported SRAM

`default_nettype none

module cpu_bus_subsys (
	input  wire                          clk,
	input  wire                          rst_n,
	// Core fetch requester
	input  wire                          bus_aph_req_i,
	input  wire [ahb_pkg::W_ADDR-1:0]    bus_haddr_i,
	input  wire [ahb_pkg::W_HSIZE-1:0]   bus_hsize_i,
	input  wire                          bus_priv_i,
	output wire                          bus_aph_ready_i,
	output wire                          bus_dph_ready_i,
	output wire                          bus_dph_err_i,
	output wire [ahb_pkg::W_DATA-1:0]    bus_rdata_i,
	// Core load/store requester
	input  wire                          bus_aph_req_d,
	input  wire [ahb_pkg::W_ADDR-1:0]    bus_haddr_d,
	input  wire [ahb_pkg::W_HSIZE-1:0]   bus_hsize_d,
	input  wire                          bus_hwrite_d,
	input  wire                          bus_priv_d,
	input  wire [ahb_pkg::W_DATA-1:0]    bus_wdata_d,
	output wire                          bus_aph_ready_d,
	output wire                          bus_dph_ready_d,
	output wire                          bus_dph_err_d,
	output wire [ahb_pkg::W_DATA-1:0]    bus_rdata_d,
	// Debug SBA requester
	input  wire                          dbg_sbus_vld,
	input  wire [ahb_pkg::W_ADDR-1:0]    dbg_sbus_addr,
	input  wire [1:0]                    dbg_sbus_size,
	input  wire                          dbg_sbus_write,
	input  wire [ahb_pkg::W_DATA-1:0]    dbg_sbus_wdata,
	output wire                          dbg_sbus_rdy,
	output wire                          dbg_sbus_err,
	output wire [ahb_pkg::W_DATA-1:0]    dbg_sbus_rdata
);

// Instruction bus
wire [ahb_pkg::W_ADDR-1:0]   i_haddr;
wire [ahb_pkg::W_HTRANS-1:0] i_htrans;
wire [ahb_pkg::W_HSIZE-1:0]  i_hsize;
wire                         i_hready;
wire                         i_hresp;
wire [ahb_pkg::W_DATA-1:0]   i_hrdata;

// Data bus
wire [ahb_pkg::W_ADDR-1:0]   d_haddr;
wire [ahb_pkg::W_HTRANS-1:0] d_htrans;
wire [ahb_pkg::W_HSIZE-1:0]  d_hsize;
wire                         d_hwrite;
wire [ahb_pkg::W_DATA-1:0]   d_hwdata;
wire                         d_hready;
wire                         d_hresp;
wire [ahb_pkg::W_DATA-1:0]   d_hrdata;

// HPROT has no consumer in the SRAM, left open on both ports
ifetch_ahb_port u_ifetch (
	.clk              (clk),
	.rst_n            (rst_n),
	.core_req_i       (bus_aph_req_i),
	.core_addr_i      (bus_haddr_i),
	.core_size_i      (bus_hsize_i),
	.core_priv_i      (bus_priv_i),
	.core_aph_ready_o (bus_aph_ready_i),
	.core_dph_ready_o (bus_dph_ready_i),
	.core_dph_err_o   (bus_dph_err_i),
	.core_rdata_o     (bus_rdata_i),
	.i_haddr_o        (i_haddr),
	.i_htrans_o       (i_htrans),
	.i_hsize_o        (i_hsize),
	.i_hprot_o        (),
	.i_hready_i       (i_hready),
	.i_hresp_i        (i_hresp),
	.i_hrdata_i       (i_hrdata)
);

dside_ahb_arbiter u_darb (
	.clk              (clk),
	.rst_n            (rst_n),
	.core_req_i       (bus_aph_req_d),
	.core_addr_i      (bus_haddr_d),
	.core_size_i      (bus_hsize_d),
	.core_write_i     (bus_hwrite_d),
	.core_priv_i      (bus_priv_d),
	.core_wdata_i     (bus_wdata_d),
	.core_aph_ready_o (bus_aph_ready_d),
	.core_dph_ready_o (bus_dph_ready_d),
	.core_dph_err_o   (bus_dph_err_d),
	.core_rdata_o     (bus_rdata_d),
	.sbus_vld_i       (dbg_sbus_vld),
	.sbus_addr_i      (dbg_sbus_addr),
	.sbus_size_i      (dbg_sbus_size),
	.sbus_write_i     (dbg_sbus_write),
	.sbus_wdata_i     (dbg_sbus_wdata),
	.sbus_rdy_o       (dbg_sbus_rdy),
	.sbus_err_o       (dbg_sbus_err),
	.sbus_rdata_o     (dbg_sbus_rdata),
	.d_haddr_o        (d_haddr),
	.d_htrans_o       (d_htrans),
	.d_hsize_o        (d_hsize),
	.d_hwrite_o       (d_hwrite),
	.d_hprot_o        (),
	.d_hwdata_o       (d_hwdata),
	.d_hready_i       (d_hready),
	.d_hresp_i        (d_hresp),
	.d_hrdata_i       (d_hrdata)
);

ahb_dual_sram u_sram (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_haddr_i  (i_haddr),
	.i_htrans_i (i_htrans),
	.i_hsize_i  (i_hsize),
	.i_hready_o (i_hready),
	.i_hresp_o  (i_hresp),
	.i_hrdata_o (i_hrdata),
	.d_haddr_i  (d_haddr),
	.d_htrans_i (d_htrans),
	.d_hsize_i  (d_hsize),
	.d_hwrite_i (d_hwrite),
	.d_hwdata_i (d_hwdata),
	.d_hready_o (d_hready),
	.d_hresp_o  (d_hresp),
	.d_hrdata_o (d_hrdata)
);

endmodule

`default_nettype wire

/* source/dside_ahb_arbiter.sv */
// Load/store side AHB-Lite master port
// Core load/store and debug SBA share one port with priority to the core

`default_nettype none

module dside_ahb_arbiter (
	input  wire                           clk,
	input  wire                           rst_n,
	// Core load/store side
	input  wire                           core_req_i,
	input  wire  [ahb_pkg::W_ADDR-1:0]    core_addr_i,
	input  wire  [ahb_pkg::W_HSIZE-1:0]   core_size_i,
	input  wire                           core_write_i,
	input  wire                           core_priv_i,
	input  wire  [ahb_pkg::W_DATA-1:0]    core_wdata_i,
	output logic                          core_aph_ready_o,
	output logic                          core_dph_ready_o,
	output logic                          core_dph_err_o,
	output logic [ahb_pkg::W_DATA-1:0]    core_rdata_o,
	// Debug system bus access side
	input  wire                           sbus_vld_i,
	input  wire  [ahb_pkg::W_ADDR-1:0]    sbus_addr_i,
	input  wire  [1:0]                    sbus_size_i,
	input  wire                           sbus_write_i,
	input  wire  [ahb_pkg::W_DATA-1:0]    sbus_wdata_i,
	output logic                          sbus_rdy_o,
	output logic                          sbus_err_o,
	output logic [ahb_pkg::W_DATA-1:0]    sbus_rdata_o,
	// AHB-Lite master side
	output logic [ahb_pkg::W_ADDR-1:0]    d_haddr_o,
	output logic [ahb_pkg::W_HTRANS-1:0]  d_htrans_o,
	output logic [ahb_pkg::W_HSIZE-1:0]   d_hsize_o,
	output logic                          d_hwrite_o,
	output logic [ahb_pkg::W_HPROT-1:0]   d_hprot_o,
	output logic [ahb_pkg::W_DATA-1:0]    d_hwdata_o,
	input  wire                           d_hready_i,
	input  wire                           d_hresp_i,
	input  wire  [ahb_pkg::W_DATA-1:0]    d_hrdata_i
);

logic gnt_core;
logic gnt_sbus;
logic gnt_core_prev;
logic gnt_sbus_prev;
logic hold_aph;
logic dph_core;
logic dph_sbus;

// --------------------------------------------------------------------------
// Grant

// A stalled address phase keeps last cycle's grant
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		hold_aph      <= 1'b0;
		gnt_core_prev <= 1'b0;
		gnt_sbus_prev <= 1'b0;
	end else begin
		hold_aph      <= (d_htrans_o == ahb_pkg::HTRANS_NSEQ) && !d_hready_i && !d_hresp_i;
		gnt_core_prev <= gnt_core;
		gnt_sbus_prev <= gnt_sbus;
	end
end

always_comb begin
	if (hold_aph) begin
		gnt_core = gnt_core_prev;
		gnt_sbus = gnt_sbus_prev;
	end else begin
		gnt_core = core_req_i;
		// SBA waits for its own previous data phase to drain
		gnt_sbus = !core_req_i && sbus_vld_i && !dph_sbus;
	end
end

// Data phase owner
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dph_core <= 1'b0;
		dph_sbus <= 1'b0;
	end else if (d_hready_i) begin
		dph_core <= gnt_core;
		dph_sbus <= gnt_sbus;
	end
end

// --------------------------------------------------------------------------
// Address and data phase muxing

assign d_htrans_o = (gnt_core || gnt_sbus) ? ahb_pkg::HTRANS_NSEQ : ahb_pkg::HTRANS_IDLE;
assign d_haddr_o  = gnt_sbus ? sbus_addr_i          : core_addr_i;
assign d_hsize_o  = gnt_sbus ? {1'b0, sbus_size_i}  : core_size_i;
assign d_hwrite_o = gnt_sbus ? sbus_write_i         : core_write_i;

// SBA always privileged
always_comb begin
	d_hprot_o = '0;
	d_hprot_o[ahb_pkg::HPROT_PRIV_BIT] = gnt_sbus || core_priv_i;
	d_hprot_o[ahb_pkg::HPROT_DATA_BIT] = 1'b1;
end

assign d_hwdata_o = dph_sbus ? sbus_wdata_i : core_wdata_i;

// Core sees the first error cycle so a trailing access can be squashed
assign core_aph_ready_o = d_hready_i && gnt_core;
assign core_dph_ready_o = d_hready_i && dph_core;
assign core_dph_err_o   = dph_core && d_hresp_i;
assign core_rdata_o     = d_hrdata_i;

assign sbus_rdy_o   = d_hready_i && dph_sbus;
assign sbus_err_o   = d_hready_i && dph_sbus && d_hresp_i;
assign sbus_rdata_o = d_hrdata_i;

a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
	!(gnt_core && gnt_sbus))
	else $error("core and SBA granted together");

// Held grant keeps the stalled address phase on the bus
a_gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
	hold_aph |-> $stable(d_haddr_o) && $stable(d_hsize_o) && $stable(d_hwrite_o))
	else $error("address phase changed under a held grant");

endmodule

`default_nettype wire

/* source/ifetch_ahb_port.sv */
// Instruction fetch AHB-Lite master port
// Turns the core fetch request into read-only single transfers

`default_nettype none

module ifetch_ahb_port (
	input  wire                           clk,
	input  wire                           rst_n,
	// Core fetch side
	input  wire                           core_req_i,
	input  wire  [ahb_pkg::W_ADDR-1:0]    core_addr_i,
	input  wire  [ahb_pkg::W_HSIZE-1:0]   core_size_i,
	input  wire                           core_priv_i,
	output logic                          core_aph_ready_o,
	output logic                          core_dph_ready_o,
	output logic                          core_dph_err_o,
	output logic [ahb_pkg::W_DATA-1:0]    core_rdata_o,
	// AHB-Lite master side
	output logic [ahb_pkg::W_ADDR-1:0]    i_haddr_o,
	output logic [ahb_pkg::W_HTRANS-1:0]  i_htrans_o,
	output logic [ahb_pkg::W_HSIZE-1:0]   i_hsize_o,
	output logic [ahb_pkg::W_HPROT-1:0]   i_hprot_o,
	input  wire                           i_hready_i,
	input  wire                           i_hresp_i,
	input  wire  [ahb_pkg::W_DATA-1:0]    i_hrdata_i
);

logic dph_active;

assign i_haddr_o  = core_addr_i;
assign i_hsize_o  = core_size_i;
assign i_htrans_o = core_req_i ? ahb_pkg::HTRANS_NSEQ : ahb_pkg::HTRANS_IDLE;

// Non-cacheable, non-bufferable opcode fetch
always_comb begin
	i_hprot_o = '0;
	i_hprot_o[ahb_pkg::HPROT_PRIV_BIT] = core_priv_i;
	i_hprot_o[ahb_pkg::HPROT_DATA_BIT] = 1'b0;
end

// Data phase follows an accepted address phase
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dph_active <= 1'b0;
	end else if (i_hready_i) begin
		dph_active <= core_req_i;
	end
end

assign core_aph_ready_o = i_hready_i && core_req_i;
assign core_dph_ready_o = i_hready_i && dph_active;
assign core_dph_err_o   = i_hready_i && dph_active && i_hresp_i;
assign core_rdata_o     = i_hrdata_i;

// Stalled request must still be on the bus next cycle
a_htrans_held: assert property (@(posedge clk) disable iff (!rst_n)
	(i_htrans_o == ahb_pkg::HTRANS_NSEQ) && !i_hready_i && !i_hresp_i
	|=> $stable(i_htrans_o))
	else $error("fetch request dropped during a stalled address phase");

endmodule

`default_nettype wire

/* source/sram_pkg.sv */
// SRAM slave geometry, data phase sequencing codes and the storage word
// The storage word is seen either as one word or as four byte lanes

`default_nettype none

package sram_pkg;

	// Geometry
	localparam int          W_INDEX   = 8;
	localparam int          MEM_WORDS = 256;
	localparam int          W_LANE    = 8;
	localparam int          N_LANES   = ahb_pkg::W_DATA / W_LANE;
	// First byte address that answers with an error
	localparam int unsigned MEM_BYTES = MEM_WORDS * N_LANES;

	// Data phase sequence per port
	// WAIT is the single data-port wait state, ERR1/ERR2 the error response
	localparam int         W_PH     = 3;
	localparam logic [2:0] PH_IDLE  = 3'd0;
	localparam logic [2:0] PH_WAIT  = 3'd1;
	localparam logic [2:0] PH_OKAY  = 3'd2;
	localparam logic [2:0] PH_ERR1  = 3'd3;
	localparam logic [2:0] PH_ERR2  = 3'd4;

	typedef union packed {
		logic [ahb_pkg::W_DATA-1:0]       word;
		logic [N_LANES-1:0][W_LANE-1:0]   lanes;
	} mem_word_u;

endpackage

`default_nettype wire

/* tb.f */
source/ahb_pkg.sv
source/sram_pkg.sv
source/ifetch_ahb_port.sv
source/dside_ahb_arbiter.sv
source/ahb_dual_sram.sv
source/cpu_bus_subsys.sv
tests/tb_cpu_bus_subsys.sv

/* tests/bus_stimulus.txt */
# name req write addr size wdata exp_rdata exp_err  (addr and data in hex)
# req 0 fetch, 1 core load/store, 2 SBA, 3 core started together with the SBA line below
cwr_w0   1 1 00000010 2 a5a5f00d 00000000 0
crd_w0   1 0 00000010 2 00000000 a5a5f00d 0
ifr_w0   0 0 00000010 2 00000000 a5a5f00d 0
cwr_w1   1 1 00000020 2 11223344 00000000 0
cwr_b1   1 1 00000021 0 0000ee00 00000000 0
cwr_h2   1 1 00000022 1 beef0000 00000000 0
crd_w1   1 0 00000020 2 00000000 beefee44 0
cwr_b3   1 1 00000023 0 77000000 00000000 0
crd_b0   1 0 00000020 0 00000000 77efee44 0
ifr_w1   0 0 00000020 2 00000000 77efee44 0
sbw_w2   2 1 00000040 2 cafe0001 00000000 0
crd_w2   1 0 00000040 2 00000000 cafe0001 0
sbr_w1   2 0 00000020 2 00000000 77efee44 0
sbw_h2   2 1 00000042 1 12340000 00000000 0
sbr_w2   2 0 00000040 2 00000000 12340001 0
prw_core 3 1 00000080 2 0badc0de 00000000 0
prw_sba  2 1 00000084 2 feedface 00000000 0
prx_core 3 1 00000090 2 13579bdf 00000000 0
prx_sba  2 0 00000090 2 00000000 13579bdf 0
prr_core 3 0 00000084 2 00000000 feedface 0
prr_sba  2 0 00000080 2 00000000 0badc0de 0
cwr_z0   1 1 00000000 2 0f0f0f0f 00000000 0
sbw_top  2 1 000003fc 2 600dcafe 00000000 0
cer_wr   1 1 00000400 2 deadbeef 00000000 1
ser_wr   2 1 00000ffc 2 deadbeef 00000000 1
cer_rd   1 0 00000800 2 00000000 00000000 1
ier_rd   0 0 00000404 2 00000000 00000000 1
chk_z0   1 0 00000000 2 00000000 0f0f0f0f 0
chk_top  0 0 000003fc 2 00000000 600dcafe 0

/* tests/tb_cpu_bus_subsys.sv */
// Testbench for the CPU bus subsystem
// Replays fetch, core load/store and SBA transactions from the stimulus file
// and checks read data, error flags, latency and core-over-SBA ordering

`default_nettype none

module tb_cpu_bus_subsys;

localparam int    PERIOD     = 20;
localparam int    MAX_LINES  = 64;
localparam int    XFER_LIMIT = 20;
localparam int    W_NAME     = 96;
localparam string STIM_FILE  = "tests/bus_stimulus.txt";
// Requester codes used in the stimulus file
localparam int    REQ_FETCH  = 0;
localparam int    REQ_CORE   = 1;
localparam int    REQ_SBA    = 2;
localparam int    REQ_PAIR   = 3;

logic                         clk = 1'b0;
logic                         rst_n;
logic                         bus_aph_req_i;
logic [ahb_pkg::W_ADDR-1:0]   bus_haddr_i;
logic [ahb_pkg::W_HSIZE-1:0]  bus_hsize_i;
logic                         bus_priv_i;
wire                          bus_aph_ready_i;
wire                          bus_dph_ready_i;
wire                          bus_dph_err_i;
wire  [ahb_pkg::W_DATA-1:0]   bus_rdata_i;
logic                         bus_aph_req_d;
logic [ahb_pkg::W_ADDR-1:0]   bus_haddr_d;
logic [ahb_pkg::W_HSIZE-1:0]  bus_hsize_d;
logic                         bus_hwrite_d;
logic                         bus_priv_d;
logic [ahb_pkg::W_DATA-1:0]   bus_wdata_d;
wire                          bus_aph_ready_d;
wire                          bus_dph_ready_d;
wire                          bus_dph_err_d;
wire  [ahb_pkg::W_DATA-1:0]   bus_rdata_d;
logic                         dbg_sbus_vld;
logic [ahb_pkg::W_ADDR-1:0]   dbg_sbus_addr;
logic [1:0]                   dbg_sbus_size;
logic                         dbg_sbus_write;
logic [ahb_pkg::W_DATA-1:0]   dbg_sbus_wdata;
wire                          dbg_sbus_rdy;
wire                          dbg_sbus_err;
wire  [ahb_pkg::W_DATA-1:0]   dbg_sbus_rdata;

// Stimulus table
logic [W_NAME-1:0]            st_name  [MAX_LINES];
int                           st_req   [MAX_LINES];
logic                         st_wr    [MAX_LINES];
logic [ahb_pkg::W_ADDR-1:0]   st_addr  [MAX_LINES];
logic [ahb_pkg::W_HSIZE-1:0]  st_size  [MAX_LINES];
logic [ahb_pkg::W_DATA-1:0]   st_wdata [MAX_LINES];
logic [ahb_pkg::W_DATA-1:0]   st_rdata [MAX_LINES];
logic                         st_err   [MAX_LINES];

int   n_lines    = 0;
int   value_errs = 0;
int   proto_errs = 0;
int   cycle      = 0;
logic loaded     = 1'b0;

cpu_bus_subsys u_cpu_bus_subsys (.*);

always #(PERIOD / 2) clk = ~clk;

always @(posedge clk) cycle <= cycle + 1;

// --------------------------------------------------------------------------
// Compare tasks

task automatic check_word(input logic [W_NAME-1:0] name,
		input logic [ahb_pkg::W_DATA-1:0] exp, input logic [ahb_pkg::W_DATA-1:0] act);
	if (act !== exp) begin
		$display("** Error %0s: read data expected %h, got %h", name, exp, act);
		value_errs++;
	end
endtask

task automatic check_flag(input logic [W_NAME-1:0] name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("** Error %0s: error flag expected %b, got %b", name, exp, act);
		value_errs++;
	end
endtask

task automatic check_cycles(input logic [W_NAME-1:0] name, input int exp, input int act);
	if (act != exp) begin
		$display("** Error %0s: latency expected %0d cycles, got %0d", name, exp, act);
		value_errs++;
	end
endtask

// Fetch has no wait state and the data port one wait state
// An error response takes the place of the wait
function automatic int expected_latency(input int kind, input logic err);
	if (kind == REQ_FETCH)
		return err ? 3 : 2;
	return 3;
endfunction

// --------------------------------------------------------------------------
// Stimulus and requesters

task automatic load_stimulus();
	int    fd;
	int    rc;
	int    f_req;
	int    f_wr;
	int    f_size;
	int    f_err;
	string line;
	logic [W_NAME-1:0]          f_name;
	logic [ahb_pkg::W_ADDR-1:0] f_addr;
	logic [ahb_pkg::W_DATA-1:0] f_wdata;
	logic [ahb_pkg::W_DATA-1:0] f_rdata;
	fd = $fopen(STIM_FILE, "r");
	if (fd == 0) begin
		$display("Cannot open the stimulus file %s", STIM_FILE);
		proto_errs++;
		return;
	end
	while ($fgets(line, fd) != 0 && n_lines < MAX_LINES) begin
		if (line.len() == 0 || line[0] == "#")
			continue;
		rc = $sscanf(line, "%s %d %d %h %d %h %h %d", f_name, f_req, f_wr, f_addr,
			f_size, f_wdata, f_rdata, f_err);
		if (rc != 8)
			continue;
		st_name[n_lines]  = f_name;
		st_req[n_lines]   = f_req;
		st_wr[n_lines]    = (f_wr != 0);
		st_addr[n_lines]  = f_addr;
		st_size[n_lines]  = f_size[2:0];
		st_wdata[n_lines] = f_wdata;
		st_rdata[n_lines] = f_rdata;
		st_err[n_lines]   = (f_err != 0);
		n_lines++;
	end
	$fclose(fd);
endtask

task automatic drive_request(input int kind, input int idx);
	case (kind)
		REQ_FETCH: begin
			bus_aph_req_i = 1'b1;
			bus_haddr_i   = st_addr[idx];
			bus_hsize_i   = st_size[idx];
		end
		REQ_SBA: begin
			dbg_sbus_vld   = 1'b1;
			dbg_sbus_addr  = st_addr[idx];
			dbg_sbus_size  = st_size[idx][1:0];
			dbg_sbus_write = st_wr[idx];
			dbg_sbus_wdata = st_wdata[idx];
		end
		default: begin
			bus_aph_req_d = 1'b1;
			bus_haddr_d   = st_addr[idx];
			bus_hsize_d   = st_size[idx];
			bus_hwrite_d  = st_wr[idx];
			bus_wdata_d   = st_wdata[idx];
		end
	endcase
endtask

task automatic release_request(input int kind);
	case (kind)
		REQ_FETCH: bus_aph_req_i = 1'b0;
		REQ_SBA:   dbg_sbus_vld  = 1'b0;
		default:   bus_aph_req_d = 1'b0;
	endcase
endtask

// One transaction with outputs sampled a quarter period after each falling edge
task automatic run_xfer(input int kind, input int idx, output int done_cyc);
	int   n;
	logic aph_seen;
	logic done;
	logic err;
	logic [ahb_pkg::W_DATA-1:0] rdata;
	n = 0;
	aph_seen = 1'b0;
	done = 1'b0;
	err = 1'b0;
	rdata = '0;
	done_cyc = 0;
	@(negedge clk);
	drive_request(kind, idx);
	while (!done && n < XFER_LIMIT) begin
		#(PERIOD / 4);
		n++;
		case (kind)
			REQ_FETCH: begin
				aph_seen = aph_seen || bus_aph_ready_i;
				done     = bus_dph_ready_i;
				err      = bus_dph_err_i;
				rdata    = bus_rdata_i;
			end
			REQ_SBA: begin
				done  = dbg_sbus_rdy || dbg_sbus_err;
				err   = dbg_sbus_err;
				rdata = dbg_sbus_rdata;
			end
			default: begin
				aph_seen = aph_seen || bus_aph_ready_d;
				done     = bus_dph_ready_d;
				err      = bus_dph_err_d;
				rdata    = bus_rdata_d;
			end
		endcase
		done_cyc = cycle;
		@(negedge clk);
		// SBA holds its valid until the end and the core only until accepted
		if (done || (aph_seen && kind != REQ_SBA))
			release_request(kind);
	end
	if (!done) begin
		$display("Requester %0d never finished line %0s", kind, st_name[idx]);
		proto_errs++;
		release_request(kind);
		return;
	end
	if (kind != REQ_SBA && !aph_seen) begin
		$display("Requester %0d finished line %0s without an address phase ready",
			kind, st_name[idx]);
		proto_errs++;
	end
	check_flag(st_name[idx], st_err[idx], err);
	if (!st_wr[idx] && !st_err[idx])
		check_word(st_name[idx], st_rdata[idx], rdata);
	if (kind != REQ_SBA)
		check_cycles(st_name[idx], expected_latency(kind, st_err[idx]), n);
endtask

// --------------------------------------------------------------------------
// Main sequence

initial begin
	int i;
	int gap;
	int cyc_core;
	int cyc_sba;
	void'($urandom(32'h53da2610));
	rst_n          = 1'b0;
	bus_aph_req_i  = 1'b0;
	bus_haddr_i    = '0;
	bus_hsize_i    = ahb_pkg::HSIZE_WORD;
	bus_priv_i     = 1'b1;
	bus_aph_req_d  = 1'b0;
	bus_haddr_d    = '0;
	bus_hsize_d    = ahb_pkg::HSIZE_WORD;
	bus_hwrite_d   = 1'b0;
	bus_priv_d     = 1'b1;
	bus_wdata_d    = '0;
	dbg_sbus_vld   = 1'b0;
	dbg_sbus_addr  = '0;
	dbg_sbus_size  = 2'b10;
	dbg_sbus_write = 1'b0;
	dbg_sbus_wdata = '0;
	load_stimulus();
	loaded = 1'b1;
	repeat (2) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;
	i = 0;
	while (i < n_lines) begin
		gap = int'($urandom_range(2));
		repeat (gap) @(negedge clk);
		if (st_req[i] == REQ_PAIR && i + 1 < n_lines) begin
			// Core and SBA start on the same edge
			fork
				run_xfer(REQ_CORE, i, cyc_core);
				run_xfer(REQ_SBA, i + 1, cyc_sba);
			join
			if (cyc_core >= cyc_sba) begin
				$display("SBA on line %0s finished before the core on line %0s",
					st_name[i + 1], st_name[i]);
				proto_errs++;
			end
			i += 2;
		end else begin
			run_xfer(st_req[i], i, cyc_core);
			i++;
		end
	end
	$display("Ran %0d lines: %0d mismatches, %0d protocol failures",
		n_lines, value_errs, proto_errs);
	if (value_errs == 0 && proto_errs == 0 && n_lines > 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
end

// Watchdog sized from the number of stimulus lines
initial begin
	wait (loaded);
	#(PERIOD * (40 * n_lines + 10));
	$display("Watchdog expired before all stimulus lines completed");
	$display("TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire
